// File: hw/tracker_pkg.sv
`default_nettype none

package tracker_pkg;

	// ========================================
	// Pixel and raster types
	// ========================================

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// Raster coordinate, column then line
	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
	} pos_t;

	// Hue in degrees, 0 to 359
	typedef logic [8:0] hue_t;

	// One pixel slot, valid on the cycle its colour is present
	typedef struct packed {
		pos_t pos;
		logic active;
		logic hs_n;
		logic vs_n;
		logic frame_start;
	} beat_t;

	// ========================================
	// Default 640x480 timing
	// ========================================

	localparam int H_ACTIVE_DEF = 640;
	localparam int H_FRONT_DEF  = 16;
	localparam int H_SYNC_DEF   = 96;
	localparam int H_BACK_DEF   = 48;

	localparam int V_ACTIVE_DEF = 480;
	localparam int V_FRONT_DEF  = 10;
	localparam int V_SYNC_DEF   = 2;
	localparam int V_BACK_DEF   = 33;

	// ========================================
	// Detection and marker
	// ========================================

	// Magenta band, both limits exclusive
	localparam int HUE_LO = 280;
	localparam int HUE_HI = 320;

	// Consecutive band pixels needed for a run
	localparam int RUN_MIN = 21;

	localparam int   MARK_RADIUS = 4;
	localparam rgb_t MARK_COLOR  = '{r: 8'd255, g: 8'd0, b: 8'd255};

endpackage

`default_nettype wire

// File: hw/vga_timing.sv
`default_nettype none

module vga_timing import tracker_pkg::*; #(
	parameter int H_ACTIVE = H_ACTIVE_DEF,
	parameter int H_FRONT  = H_FRONT_DEF,
	parameter int H_SYNC   = H_SYNC_DEF,
	parameter int H_BACK   = H_BACK_DEF,
	parameter int V_ACTIVE = V_ACTIVE_DEF,
	parameter int V_FRONT  = V_FRONT_DEF,
	parameter int V_SYNC   = V_SYNC_DEF,
	parameter int V_BACK   = V_BACK_DEF
) (
	input  wire logic  VGA_CLK,
	input  wire logic  reset,
	output logic       pixel_req,
	output beat_t      beat
);

	// Active area first, then front porch, sync, back porch
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
	localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
	localparam int H_TOTAL      = H_SYNC_END + H_BACK;
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
	localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;
	localparam int V_TOTAL      = V_SYNC_END + V_BACK;

	logic       run;
	logic [9:0] h_cnt;
	logic [9:0] v_cnt;
	beat_t      slot;

	// ========================================
	// Counters
	// ========================================

	// Counters hold at (0,0) for one cycle after reset so that
	// the first request lands on the top-left pixel
	always_ff @(posedge VGA_CLK) begin
		if (reset) begin
			run   <= 1'b0;
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			run <= 1'b1;
			if (run) begin
				if (h_cnt == 10'(H_TOTAL - 1)) begin
					h_cnt <= '0;
					if (v_cnt == 10'(V_TOTAL - 1))
						v_cnt <= '0;
					else
						v_cnt <= v_cnt + 10'd1;
				end else begin
					h_cnt <= h_cnt + 10'd1;
				end
			end
		end
	end

	// ========================================
	// Request and slot
	// ========================================

	assign pixel_req = run && (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);

	always_comb begin
		slot.pos.x       = h_cnt;
		slot.pos.y       = v_cnt;
		slot.active      = pixel_req;
		slot.hs_n        = !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
		slot.vs_n        = !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));
		slot.frame_start = run && (h_cnt == '0) && (v_cnt == '0);
	end

	// Delay by one so the slot lines up with the returned colour
	always_ff @(posedge VGA_CLK) begin
		if (reset) begin
			beat <= '{pos: '0, active: 1'b0, hs_n: 1'b1, vs_n: 1'b1, frame_start: 1'b0};
		end else begin
			beat <= slot;
		end
	end

	// Requests never overlap a sync pulse and stay inside the raster
	a_req_in_active: assert property (@(posedge VGA_CLK) disable iff (reset)
		pixel_req |-> (slot.hs_n && slot.vs_n && h_cnt < H_TOTAL && v_cnt < V_TOTAL));

endmodule

`default_nettype wire

// File: hw/hue_pipe.sv
`default_nettype none

module hue_pipe import tracker_pkg::*; (
	input  wire logic  VGA_CLK,
	input  wire logic  reset,
	input  wire rgb_t  pixel_in,
	input  wire beat_t beat,
	output hue_t       hue_out,
	output pos_t       hue_pos,
	output logic       hue_valid
);

	localparam logic [1:0] CH_RED   = 2'd0;
	localparam logic [1:0] CH_GREEN = 2'd1;
	localparam logic [1:0] CH_BLUE  = 2'd2;

	// Stage 1 results
	logic [1:0]        dom_c;
	logic [7:0]        max_c;
	logic [7:0]        min_c;
	logic signed [8:0] diff_c;
	logic [1:0]        s1_dom;
	logic [7:0]        s1_delta;
	logic signed [8:0] s1_diff;
	pos_t              s1_pos;
	logic              s1_valid;

	// Stage 2 results
	logic signed [15:0] prod_c;
	logic signed [15:0] quot_c;
	logic [1:0]         s2_dom;
	logic signed [7:0]  s2_q;
	logic               s2_grey;
	pos_t               s2_pos;
	logic               s2_valid;

	// Stage 3
	logic signed [9:0] base_c;
	logic signed [9:0] sum_c;
	hue_t              hue_c;

	// ========================================
	// Stage 1: extremes and dominant channel
	// ========================================

	// Ties go to blue, then green, then red
	always_comb begin
		if (pixel_in.b >= pixel_in.r && pixel_in.b >= pixel_in.g) begin
			dom_c  = CH_BLUE;
			max_c  = pixel_in.b;
			diff_c = $signed({1'b0, pixel_in.r}) - $signed({1'b0, pixel_in.g});
		end else if (pixel_in.g >= pixel_in.r) begin
			dom_c  = CH_GREEN;
			max_c  = pixel_in.g;
			diff_c = $signed({1'b0, pixel_in.b}) - $signed({1'b0, pixel_in.r});
		end else begin
			dom_c  = CH_RED;
			max_c  = pixel_in.r;
			diff_c = $signed({1'b0, pixel_in.g}) - $signed({1'b0, pixel_in.b});
		end
		min_c = pixel_in.r;
		if (pixel_in.g < min_c)
			min_c = pixel_in.g;
		if (pixel_in.b < min_c)
			min_c = pixel_in.b;
	end

	always_ff @(posedge VGA_CLK) begin
		s1_dom   <= dom_c;
		s1_delta <= max_c - min_c;
		s1_diff  <= diff_c;
		s1_pos   <= beat.pos;
	end

	// ========================================
	// Stage 2: scaled difference over range
	// ========================================

	// Signed divide truncates toward zero, quotient stays within +-60
	always_comb begin
		prod_c = s1_diff * 16'sd60;
		if (s1_delta == '0)
			quot_c = '0;
		else
			quot_c = prod_c / $signed({8'd0, s1_delta});
	end

	always_ff @(posedge VGA_CLK) begin
		s2_dom  <= s1_dom;
		s2_q    <= quot_c[7:0];
		s2_grey <= (s1_delta == '0);
		s2_pos  <= s1_pos;
	end

	// ========================================
	// Stage 3: base offset and wrap
	// ========================================

	always_comb begin
		case (s2_dom)
			CH_GREEN: base_c = 10'sd120;
			CH_BLUE:  base_c = 10'sd240;
			default:  base_c = 10'sd0;
		endcase
		sum_c = base_c + {{2{s2_q[7]}}, s2_q};
		if (sum_c < 0)
			sum_c = sum_c + 10'sd360;
		hue_c = s2_grey ? '0 : sum_c[8:0];
	end

	always_ff @(posedge VGA_CLK) begin
		hue_out <= hue_c;
		hue_pos <= s2_pos;
	end

	// Valid bits travel alongside the payload
	always_ff @(posedge VGA_CLK) begin
		if (reset) begin
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
			hue_valid <= 1'b0;
		end else begin
			s1_valid  <= beat.active;
			s2_valid  <= s1_valid;
			hue_valid <= s2_valid;
		end
	end

	a_hue_range: assert property (@(posedge VGA_CLK) disable iff (reset)
		beat.active |-> ##3 (hue_valid && hue_out < 9'd360));

endmodule

`default_nettype wire

// File: hw/magenta_tracker.sv
`default_nettype none

module magenta_tracker import tracker_pkg::*; (
	input  wire logic VGA_CLK,
	input  wire logic reset,
	input  wire hue_t hue_out,
	input  wire pos_t hue_pos,
	input  wire logic hue_valid,
	input  wire logic frame_start,
	output pos_t      shown_pos,
	output hue_t      shown_hue,
	output logic      shown_valid
);

	localparam int CW = $clog2(RUN_MIN + 1);

	logic [CW-1:0] run_cnt;
	logic [CW-1:0] cnt_next;
	logic          in_band;
	logic          qualify;
	pos_t          work_pos;
	hue_t          work_hue;
	logic          work_valid;

	// ========================================
	// Run detection
	// ========================================

	assign in_band = (hue_out > HUE_LO) && (hue_out < HUE_HI);

	// Saturates at RUN_MIN so every later band pixel still qualifies
	always_comb begin
		if (run_cnt == CW'(RUN_MIN))
			cnt_next = run_cnt;
		else
			cnt_next = run_cnt + 1'b1;
	end

	assign qualify = hue_valid && in_band && (cnt_next == CW'(RUN_MIN));

	// Blanking slots leave the count alone
	always_ff @(posedge VGA_CLK) begin
		if (reset)
			run_cnt <= '0;
		else if (frame_start)
			run_cnt <= '0;
		else if (hue_valid)
			run_cnt <= in_band ? cnt_next : '0;
	end

	// ========================================
	// Working and shown copies
	// ========================================

	always_ff @(posedge VGA_CLK) begin
		if (qualify && !frame_start) begin
			work_pos <= hue_pos;
			work_hue <= hue_out;
		end
		if (frame_start) begin
			shown_pos <= work_pos;
			shown_hue <= work_hue;
		end
	end

	always_ff @(posedge VGA_CLK) begin
		if (reset) begin
			work_valid  <= 1'b0;
			shown_valid <= 1'b0;
		end else if (frame_start) begin
			shown_valid <= work_valid;
			work_valid  <= 1'b0;
		end else if (qualify) begin
			work_valid <= 1'b1;
		end
	end

	a_cnt_limit: assert property (@(posedge VGA_CLK) disable iff (reset)
		run_cnt <= CW'(RUN_MIN));

endmodule

`default_nettype wire

// File: hw/marker_overlay.sv
`default_nettype none

module marker_overlay import tracker_pkg::*; (
	input  wire logic  VGA_CLK,
	input  wire logic  reset,
	input  wire rgb_t  pixel_in,
	input  wire beat_t beat,
	input  wire pos_t  shown_pos,
	input  wire logic  shown_valid,
	output rgb_t       vga_rgb,
	output logic       vga_hs,
	output logic       vga_vs,
	output logic       vga_blank_n
);

	logic [9:0] dx;
	logic [9:0] dy;
	logic       in_mark;
	rgb_t       rgb_c;

	// ========================================
	// Marker square test
	// ========================================

	// Absolute distances, no wrap at the screen edge
	always_comb begin
		if (beat.pos.x >= shown_pos.x)
			dx = beat.pos.x - shown_pos.x;
		else
			dx = shown_pos.x - beat.pos.x;
		if (beat.pos.y >= shown_pos.y)
			dy = beat.pos.y - shown_pos.y;
		else
			dy = shown_pos.y - beat.pos.y;
	end

	assign in_mark = shown_valid && (dx <= MARK_RADIUS) && (dy <= MARK_RADIUS);

	always_comb begin
		if (!beat.active)
			rgb_c = '0;
		else if (in_mark)
			rgb_c = MARK_COLOR;
		else
			rgb_c = pixel_in;
	end

	// ========================================
	// Output register
	// ========================================

	always_ff @(posedge VGA_CLK) begin
		vga_rgb <= rgb_c;
	end

	// Syncs idle high, active low
	always_ff @(posedge VGA_CLK) begin
		if (reset) begin
			vga_hs      <= 1'b1;
			vga_vs      <= 1'b1;
			vga_blank_n <= 1'b0;
		end else begin
			vga_hs      <= beat.hs_n;
			vga_vs      <= beat.vs_n;
			vga_blank_n <= beat.active;
		end
	end

endmodule

`default_nettype wire

// File: hw/hue_readout.sv
`default_nettype none

module hue_readout import tracker_pkg::*; (
	input  wire hue_t shown_hue,
	input  wire logic shown_valid,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2
);

	logic [8:0] hundreds;
	logic [8:0] tens;
	logic [8:0] ones;

	// Active-low segments, bit 0 is a and bit 6 is g
	function automatic logic [6:0] seg7(input logic [3:0] digit);
		case (digit)
			4'd0:    seg7 = 7'h40;
			4'd1:    seg7 = 7'h79;
			4'd2:    seg7 = 7'h24;
			4'd3:    seg7 = 7'h30;
			4'd4:    seg7 = 7'h19;
			4'd5:    seg7 = 7'h12;
			4'd6:    seg7 = 7'h02;
			4'd7:    seg7 = 7'h78;
			4'd8:    seg7 = 7'h00;
			4'd9:    seg7 = 7'h10;
			default: seg7 = 7'h7F;
		endcase
	endfunction

	// ========================================
	// Decimal split
	// ========================================

	always_comb begin
		hundreds = shown_hue / 9'd100;
		tens     = (shown_hue / 9'd10) % 9'd10;
		ones     = shown_hue % 9'd10;
	end

	// All segments off until a run has been tracked
	always_comb begin
		if (shown_valid) begin
			hex0 = seg7(ones[3:0]);
			hex1 = seg7(tens[3:0]);
			hex2 = seg7(hundreds[3:0]);
		end else begin
			hex0 = 7'h7F;
			hex1 = 7'h7F;
			hex2 = 7'h7F;
		end
	end

endmodule

`default_nettype wire

// File: hw/hue_tracker_top.sv
`default_nettype none

module hue_tracker_top import tracker_pkg::*; #(
	parameter int H_ACTIVE = H_ACTIVE_DEF,
	parameter int H_FRONT  = H_FRONT_DEF,
	parameter int H_SYNC   = H_SYNC_DEF,
	parameter int H_BACK   = H_BACK_DEF,
	parameter int V_ACTIVE = V_ACTIVE_DEF,
	parameter int V_FRONT  = V_FRONT_DEF,
	parameter int V_SYNC   = V_SYNC_DEF,
	parameter int V_BACK   = V_BACK_DEF
) (
	input  wire logic  VGA_CLK,
	input  wire logic  reset,
	output logic       pixel_req,
	input  wire rgb_t  pixel_in,
	output rgb_t       vga_rgb,
	output logic       vga_hs,
	output logic       vga_vs,
	output logic       vga_blank_n,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2
);

	beat_t beat;
	hue_t  hue_val;
	pos_t  hue_pos;
	logic  hue_valid;
	pos_t  shown_pos;
	hue_t  shown_hue;
	logic  shown_valid;

	// ========================================
	// Raster and hue path
	// ========================================

	vga_timing #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT (H_FRONT),
		.H_SYNC  (H_SYNC),
		.H_BACK  (H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT (V_FRONT),
		.V_SYNC  (V_SYNC),
		.V_BACK  (V_BACK)
	) vga_timing_i (
		.VGA_CLK  (VGA_CLK),
		.reset    (reset),
		.pixel_req(pixel_req),
		.beat     (beat)
	);

	hue_pipe hue_pipe_i (
		.VGA_CLK  (VGA_CLK),
		.reset    (reset),
		.pixel_in (pixel_in),
		.beat     (beat),
		.hue_out  (hue_val),
		.hue_pos  (hue_pos),
		.hue_valid(hue_valid)
	);

	magenta_tracker magenta_tracker_i (
		.VGA_CLK    (VGA_CLK),
		.reset      (reset),
		.hue_out    (hue_val),
		.hue_pos    (hue_pos),
		.hue_valid  (hue_valid),
		.frame_start(beat.frame_start),
		.shown_pos  (shown_pos),
		.shown_hue  (shown_hue),
		.shown_valid(shown_valid)
	);

	// ========================================
	// Outputs
	// ========================================

	marker_overlay marker_overlay_i (
		.VGA_CLK    (VGA_CLK),
		.reset      (reset),
		.pixel_in   (pixel_in),
		.beat       (beat),
		.shown_pos  (shown_pos),
		.shown_valid(shown_valid),
		.vga_rgb    (vga_rgb),
		.vga_hs     (vga_hs),
		.vga_vs     (vga_vs),
		.vga_blank_n(vga_blank_n)
	);

	hue_readout hue_readout_i (
		.shown_hue  (shown_hue),
		.shown_valid(shown_valid),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex2       (hex2)
	);

endmodule

`default_nettype wire

// File: verif/tb_hue_tracker.sv
`default_nettype none

module tb_hue_tracker import tracker_pkg::*;;

	timeunit 1ns;
	timeprecision 1ps;

	// Small raster for simulation
	localparam int H_ACT = 64;
	localparam int H_FP = 8;
	localparam int H_SW = 8;
	localparam int H_BP = 8;
	localparam int V_ACT = 48;
	localparam int V_FP = 2;
	localparam int V_SW = 2;
	localparam int V_BP = 2;

	localparam int H_TOT = H_ACT + H_FP + H_SW + H_BP;
	localparam int V_TOT = V_ACT + V_FP + V_SW + V_BP;
	localparam int FRAME_CYC = H_TOT * V_TOT;
	localparam int PIX = H_ACT * V_ACT;
	localparam int N_FRAMES = 7;
	localparam int TOTAL_PIX = N_FRAMES * PIX;
	localparam int WATCHDOG_NS = (N_FRAMES + 2) * FRAME_CYC * 10;
	localparam rgb_t PLANT = '{r: 8'd200, g: 8'd0, b: 8'd200};

	logic       VGA_CLK = 1'b0;
	logic       reset = 1'b1;
	logic       pixel_req;
	rgb_t       pixel_in = '0;
	rgb_t       vga_rgb;
	logic       vga_hs;
	logic       vga_vs;
	logic       vga_blank_n;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;

	// Stimulus image and per-frame expected tracking
	rgb_t img [TOTAL_PIX];
	int   run_len [N_FRAMES] = '{25, 20, 21, 0, 0, 20, 0};
	logic trk_valid [N_FRAMES];
	int   trk_x [N_FRAMES];
	int   trk_y [N_FRAMES];
	int   trk_hue [N_FRAMES];

	logic pend = 1'b0;
	int   pend_idx = 0;
	int   req_cnt = 0;
	int   out_idx = 0;
	int   vs_falls = 0;
	int   hs_in_frame = 0;
	int   blank_in_frame = 0;
	logic prev_hs = 1'b1;
	logic prev_vs = 1'b1;
	int   checks = 0;
	int   errors = 0;

	hue_tracker_top #(
		.H_ACTIVE(H_ACT),
		.H_FRONT (H_FP),
		.H_SYNC  (H_SW),
		.H_BACK  (H_BP),
		.V_ACTIVE(V_ACT),
		.V_FRONT (V_FP),
		.V_SYNC  (V_SW),
		.V_BACK  (V_BP)
	) hue_tracker_top_i (
		.VGA_CLK    (VGA_CLK),
		.reset      (reset),
		.pixel_req  (pixel_req),
		.pixel_in   (pixel_in),
		.vga_rgb    (vga_rgb),
		.vga_hs     (vga_hs),
		.vga_vs     (vga_vs),
		.vga_blank_n(vga_blank_n),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex2       (hex2)
	);

	always #5 VGA_CLK = !VGA_CLK;

	// ========================================
	// Reference model
	// ========================================

	function automatic int ref_hue(input rgb_t c);
		int r;
		int g;
		int b;
		int mx;
		int mn;
		int diff;
		int base;
		int h;
		r = c.r;
		g = c.g;
		b = c.b;
		mn = r;
		if (g < mn)
			mn = g;
		if (b < mn)
			mn = b;
		if (b >= r && b >= g) begin
			mx = b;
			diff = r - g;
			base = 240;
		end else if (g >= r) begin
			mx = g;
			diff = b - r;
			base = 120;
		end else begin
			mx = r;
			diff = g - b;
			base = 0;
		end
		if (mx == mn)
			return 0;
		h = base + (60 * diff) / (mx - mn);
		if (h < 0)
			h = h + 360;
		return h;
	endfunction

	function automatic logic in_band(input int h);
		return (h > HUE_LO) && (h < HUE_HI);
	endfunction

	// Last pixel of the frame that completes or extends a qualifying run
	function automatic void track_frame(input int f);
		int cnt;
		int h;
		cnt = 0;
		trk_valid[f] = 1'b0;
		trk_x[f] = 0;
		trk_y[f] = 0;
		trk_hue[f] = 0;
		for (int k = 0; k < PIX; k++) begin
			h = ref_hue(img[f * PIX + k]);
			if (in_band(h)) begin
				if (cnt < RUN_MIN)
					cnt = cnt + 1;
				if (cnt >= RUN_MIN) begin
					trk_valid[f] = 1'b1;
					trk_x[f] = k % H_ACT;
					trk_y[f] = k / H_ACT;
					trk_hue[f] = h;
				end
			end else begin
				cnt = 0;
			end
		end
	endfunction

	function automatic rgb_t expected_color(input int f, input int x, input int y,
			input rgb_t supplied);
		int dx;
		int dy;
		if (f == 0 || !trk_valid[f - 1])
			return supplied;
		dx = (x >= trk_x[f - 1]) ? x - trk_x[f - 1] : trk_x[f - 1] - x;
		dy = (y >= trk_y[f - 1]) ? y - trk_y[f - 1] : trk_y[f - 1] - y;
		if (dx <= MARK_RADIUS && dy <= MARK_RADIUS)
			return MARK_COLOR;
		return supplied;
	endfunction

	// Active-low segments, a in bit 0
	function automatic logic [6:0] seg_code(input int d);
		case (d)
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			9: return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

	function automatic logic [6:0] expected_hex(input int f, input int place);
		if (f == 0 || !trk_valid[f - 1])
			return 7'b1111111;
		return seg_code((trk_hue[f - 1] / place) % 10);
	endfunction

	// ========================================
	// Stimulus
	// ========================================

	// Random background outside the band, then one planted run per frame
	task automatic build_frames();
		logic [31:0] rnd;
		rgb_t        c;
		int          y;
		int          x0;
		for (int f = 0; f < N_FRAMES; f++) begin
			for (int k = 0; k < PIX; k++) begin
				rnd = $urandom;
				c = rnd[23:0];
				while (in_band(ref_hue(c))) begin
					rnd = $urandom;
					c = rnd[23:0];
				end
				img[f * PIX + k] = c;
			end
			if (run_len[f] > 0) begin
				y = $urandom % V_ACT;
				x0 = $urandom % (H_ACT - run_len[f] + 1);
				for (int i = 0; i < run_len[f]; i++)
					img[f * PIX + y * H_ACT + x0 + i] = PLANT;
			end
		end
	endtask

	function automatic rgb_t supplied_color(input int idx);
		if (idx < TOTAL_PIX)
			return img[idx];
		return '0;
	endfunction

	// Colour follows its request by one cycle
	always @(negedge VGA_CLK) begin
		if (pend)
			pixel_in <= supplied_color(pend_idx);
		else
			pixel_in <= '0;
		pend = pixel_req && !reset;
		pend_idx = req_cnt;
		if (pend)
			req_cnt = req_cnt + 1;
	end

	// ========================================
	// Checking
	// ========================================

	task automatic check(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks = checks + 1;
		if (got !== exp) begin
			errors = errors + 1;
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	always @(negedge VGA_CLK) begin : compare_outputs
		int f;
		int k;
		if (reset) begin
			check("pixel_req", pixel_req, 0);
			check("vga_blank_n", vga_blank_n, 0);
			check("vga_hs", vga_hs, 1);
			check("vga_vs", vga_vs, 1);
			check("hex0", hex0, 7'h7F);
			check("hex1", hex1, 7'h7F);
			check("hex2", hex2, 7'h7F);
		end else begin
			if (vga_blank_n) begin
				blank_in_frame = blank_in_frame + 1;
				if (out_idx < TOTAL_PIX) begin
					f = out_idx / PIX;
					k = out_idx % PIX;
					check("vga_rgb", vga_rgb,
						expected_color(f, k % H_ACT, k / H_ACT, img[out_idx]));
					check("hex0", hex0, expected_hex(f, 1));
					check("hex1", hex1, expected_hex(f, 10));
					check("hex2", hex2, expected_hex(f, 100));
				end
				out_idx = out_idx + 1;
			end
			if (prev_hs && !vga_hs)
				hs_in_frame = hs_in_frame + 1;
			// One whole frame lies between two vsync falls
			if (prev_vs && !vga_vs) begin
				vs_falls = vs_falls + 1;
				if (vs_falls > 1) begin
					check("blank_n high per frame", blank_in_frame, PIX);
					check("hsync falls per frame", hs_in_frame, V_TOT);
				end
				blank_in_frame = 0;
				hs_in_frame = 0;
			end
		end
		prev_hs = vga_hs;
		prev_vs = vga_vs;
	end

	task automatic report_and_finish();
		$display("Done: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	endtask

	initial begin
		void'($urandom(32'ha026fbde));
		run_len[4] = 22 + ($urandom % 9);
		build_frames();
		for (int f = 0; f < N_FRAMES; f++)
			track_frame(f);
		repeat (10) @(negedge VGA_CLK);
		reset <= 1'b0;
		wait (vs_falls == N_FRAMES);
		check("output pixel count", out_idx, TOTAL_PIX);
		report_and_finish();
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: outputs for %0d frames did not arrive within %0d ns",
			N_FRAMES, WATCHDOG_NS);
		errors = errors + 1;
		report_and_finish();
	end

endmodule

`default_nettype wire

// File: vlog.f
hw/tracker_pkg.sv
hw/vga_timing.sv
hw/hue_pipe.sv
hw/magenta_tracker.sv
hw/marker_overlay.sv
hw/hue_readout.sv
hw/hue_tracker_top.sv
verif/tb_hue_tracker.sv

// File: Bender.yml
package:
  name: hue_tracker

sources:
  - hw/tracker_pkg.sv
  - hw/vga_timing.sv
  - hw/hue_pipe.sv
  - hw/magenta_tracker.sv
  - hw/marker_overlay.sv
  - hw/hue_readout.sv
  - hw/hue_tracker_top.sv
  - target: test
    files:
      - verif/tb_hue_tracker.sv
